//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP = scoreDisplayTb
FILELIST = vlog.f
PASS_TEXT = ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- src/numberBitmap.sv
`timescale 1ns/1ps

module numberBitmap (
	input logic clk,
	input logic arstN,
	input scorePkg::offset_t offsetX,
	input scorePkg::offset_t offsetY,
	input scorePkg::digit_t number,
	input logic insideRectangle,
	output logic drawNumber,
	output scorePkg::rgb_t RGBNumber
);

	// five rows of three bits, row 0 is the top of the glyph
	typedef logic [4:0][2:0] glyph_t;

	localparam glyph_t FONT [10] = '{
		15'b111_101_101_101_111, // 0
		15'b001_001_001_001_001, // 1
		15'b111_001_111_100_111, // 2
		15'b111_001_111_001_111, // 3
		15'b101_101_111_001_001, // 4
		15'b111_100_111_001_111, // 5
		15'b111_100_111_101_111, // 6
		15'b111_001_001_001_001, // 7
		15'b111_101_111_101_111, // 8
		15'b111_101_111_001_111 // 9
	};

	localparam scorePkg::offset_t SCALE = scorePkg::offset_t'(scorePkg::FONT_SCALE);
	localparam scorePkg::offset_t FONT_ROWS = 11'd5;
	localparam scorePkg::offset_t FONT_COLS = 11'd3;

	glyph_t glyph;
	scorePkg::offset_t fontRow;
	scorePkg::offset_t fontCol;
	logic lit;

	assign fontRow = offsetY / SCALE;
	assign fontCol = offsetX / SCALE;

	assign glyph = (number < 4'd10) ? FONT[number] : '0; // codes above nine stay blank

	// packed index 4 holds the top row and bit 2 the left column
	always_comb begin
		lit = 1'b0;
		if (insideRectangle && (fontRow < FONT_ROWS) && (fontCol < FONT_COLS)) begin
			lit = glyph[3'd4 - fontRow[2:0]][2'd2 - fontCol[1:0]];
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			drawNumber <= 1'b0;
			RGBNumber <= scorePkg::BACKGROUND_COLOR;
		end else begin
			drawNumber <= lit;
			RGBNumber <= lit ? scorePkg::DIGIT_COLOR : scorePkg::BACKGROUND_COLOR;
		end
	end

endmodule

//--- src/objectsMux.sv
`timescale 1ns/1ps

module objectsMux (
	input logic clk,
	input logic arstN,
	input logic drawObstacle,
	input logic drawScoreNumber,
	input scorePkg::rgb_t RGBObstacle,
	output logic drawPixel,
	output logic drawScore,
	output scorePkg::rgb_t rgb
);

	scorePkg::rgb_t nextRgb;

	// the highlighted digit wins over an ordinary one
	always_comb begin
		if (drawScoreNumber) begin
			nextRgb = scorePkg::SCORE_COLOR;
		end else if (drawObstacle) begin
			nextRgb = RGBObstacle;
		end else begin
			nextRgb = scorePkg::BACKGROUND_COLOR;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			drawPixel <= 1'b0;
			drawScore <= 1'b0;
			rgb <= scorePkg::BACKGROUND_COLOR;
		end else begin
			drawPixel <= drawObstacle;
			drawScore <= drawScoreNumber;
			rgb <= nextRgb;
		end
	end

endmodule

//--- src/obstacle.sv
`timescale 1ns/1ps

module obstacle #(
	parameter int NUMBERS = 10,
	parameter int NUMBERS_SPACE = 40,
	parameter int ROW_LEFT_X = 20,
	parameter int ROW_TOP_Y = 60
) (
	input logic clk,
	input logic arstN,
	input scorePkg::pixelCoord_t pixelX,
	input scorePkg::pixelCoord_t pixelY,
	input scorePkg::digit_t scoreNumber,
	output logic drawObstacle,
	output scorePkg::rgb_t RGBObstacle,
	output logic drawScoreNumber
);

	logic [NUMBERS-1:0] drawSquare;
	scorePkg::offset_t offsetXSquare [NUMBERS];
	scorePkg::offset_t offsetYSquare [NUMBERS];

	for (genvar i = 0; i < NUMBERS; i++) begin : genSquares
		square #(
			.OBJECT_WIDTH(scorePkg::NUMBER_WIDTH),
			.OBJECT_HEIGHT(scorePkg::NUMBER_HEIGHT),
			.TOP_LEFT_X(ROW_LEFT_X + i * NUMBERS_SPACE),
			.TOP_LEFT_Y(ROW_TOP_Y)
		) squareInst (
			.pixelX(pixelX),
			.pixelY(pixelY),
			.draw(drawSquare[i]),
			.offsetX(offsetXSquare[i]),
			.offsetY(offsetYSquare[i])
		);
	end

	scorePkg::digit_t numberToDraw;
	scorePkg::offset_t offsetXNumber;
	scorePkg::offset_t offsetYNumber;
	scorePkg::digit_t drawnDigit;
	logic insideRectangle;
	logic drawNumber;
	scorePkg::rgb_t RGBNumber;

	// cells never overlap, so the last hit is the only hit
	always_comb begin
		numberToDraw = '0;
		offsetXNumber = offsetXSquare[0];
		offsetYNumber = offsetYSquare[0];
		for (int i = 1; i < NUMBERS; i++) begin
			if (drawSquare[i]) begin
				numberToDraw = scorePkg::digit_t'(i);
				offsetXNumber = offsetXSquare[i];
				offsetYNumber = offsetYSquare[i];
			end
		end
	end

	assign insideRectangle = |drawSquare;

	numberBitmap numberBitmapInst (
		.clk(clk),
		.arstN(arstN),
		.offsetX(offsetXNumber),
		.offsetY(offsetYNumber),
		.number(numberToDraw),
		.insideRectangle(insideRectangle),
		.drawNumber(drawNumber),
		.RGBNumber(RGBNumber)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			drawnDigit <= '0;
		end else begin
			drawnDigit <= numberToDraw; // lines up with drawNumber from the bitmap
		end
	end

	assign drawObstacle = drawNumber;
	assign RGBObstacle = RGBNumber;
	assign drawScoreNumber = drawNumber && (drawnDigit == scoreNumber);

endmodule

//--- src/scoreDisplayTop.sv
`timescale 1ns/1ps

module scoreDisplayTop #(
	parameter int NUMBERS = 10,
	parameter int NUMBERS_SPACE = 40,
	parameter int ROW_LEFT_X = 20,
	parameter int ROW_TOP_Y = 60
) (
	input logic clk,
	input logic arstN,
	input scorePkg::pixelCoord_t pixelX, // straight from the sync counter
	input scorePkg::pixelCoord_t pixelY,
	input scorePkg::digit_t scoreNumber,
	output logic drawPixel,
	output logic drawScore,
	output scorePkg::rgb_t rgb
);

	logic drawObstacle;
	logic drawScoreNumber;
	scorePkg::rgb_t RGBObstacle;

	obstacle #(
		.NUMBERS(NUMBERS),
		.NUMBERS_SPACE(NUMBERS_SPACE),
		.ROW_LEFT_X(ROW_LEFT_X),
		.ROW_TOP_Y(ROW_TOP_Y)
	) obstacleInst (
		.clk(clk),
		.arstN(arstN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.scoreNumber(scoreNumber),
		.drawObstacle(drawObstacle),
		.RGBObstacle(RGBObstacle),
		.drawScoreNumber(drawScoreNumber)
	);

	objectsMux objectsMuxInst (
		.clk(clk),
		.arstN(arstN),
		.drawObstacle(drawObstacle),
		.drawScoreNumber(drawScoreNumber),
		.RGBObstacle(RGBObstacle),
		.drawPixel(drawPixel),
		.drawScore(drawScore),
		.rgb(rgb)
	);

endmodule

//--- src/scorePkg.sv
package scorePkg;

	// size of one digit cell on screen
	localparam int NUMBER_WIDTH = 24; // three font columns
	localparam int NUMBER_HEIGHT = 40; // five font rows

	// every font bit becomes a square block of this many pixels
	localparam int FONT_SCALE = 8;

	// coordinates can be negative before the visible area starts
	typedef logic signed [10:0] pixelCoord_t;

	typedef logic [10:0] offset_t; // distance from the top-left corner of a rectangle

	typedef logic [3:0] digit_t;

	typedef logic [7:0] rgb_t; // RRRGGGBB

	localparam rgb_t DIGIT_COLOR = 8'hFF; // white
	localparam rgb_t SCORE_COLOR = 8'hE0; // full red with no green or blue
	localparam rgb_t BACKGROUND_COLOR = 8'h00;

endpackage

//--- src/square.sv
`timescale 1ns/1ps

module square #(
	parameter int OBJECT_WIDTH = 24,
	parameter int OBJECT_HEIGHT = 40,
	parameter int TOP_LEFT_X = 0,
	parameter int TOP_LEFT_Y = 0
) (
	input scorePkg::pixelCoord_t pixelX,
	input scorePkg::pixelCoord_t pixelY,
	output logic draw,
	output scorePkg::offset_t offsetX,
	output scorePkg::offset_t offsetY
);

	localparam scorePkg::pixelCoord_t LEFT = scorePkg::pixelCoord_t'(TOP_LEFT_X);
	localparam scorePkg::pixelCoord_t TOP = scorePkg::pixelCoord_t'(TOP_LEFT_Y);
	localparam scorePkg::pixelCoord_t RIGHT =
		scorePkg::pixelCoord_t'(TOP_LEFT_X + OBJECT_WIDTH);
	localparam scorePkg::pixelCoord_t BOTTOM =
		scorePkg::pixelCoord_t'(TOP_LEFT_Y + OBJECT_HEIGHT);

	scorePkg::pixelCoord_t relX;
	scorePkg::pixelCoord_t relY;
	logic insideX;
	logic insideY;

	assign relX = pixelX - LEFT;
	assign relY = pixelY - TOP;

	assign insideX = (pixelX >= LEFT) && (pixelX < RIGHT); // right column belongs to the gap
	assign insideY = (pixelY >= TOP) && (pixelY < BOTTOM);
	assign draw = insideX && insideY;

	always_comb begin
		offsetX = '0;
		offsetY = '0;
		if (draw) begin
			offsetX = scorePkg::offset_t'(relX); // never negative once inside
			offsetY = scorePkg::offset_t'(relY);
		end
	end

endmodule

//--- verification/scoreDisplayCases.txt
# name pixelX pixelY score drawPixel drawScore rgb(hex)
# score is the current score that the pixel's cell is compared with
lit0 20 60 5 1 0 FF
unlit0 30 78 5 0 0 00
lit1 80 70 0 1 0 FF
unlit1 62 70 0 0 0 00
lit2 102 88 7 1 0 FF
unlit2 102 70 7 0 0 00
lit3 150 78 4 1 0 FF
unlit3 142 88 4 0 0 00
lit4 198 62 9 1 0 FF
unlit4 190 62 9 0 0 00
lit5 222 70 2 1 0 FF
unlit5 238 70 2 0 0 00
lit6 278 88 0 1 0 FF
unlit6 270 88 0 0 0 00
lit7 318 96 1 1 0 FF
unlit7 302 96 1 0 0 00
lit8 342 70 3 1 0 FF
unlit8 350 70 3 0 0 00
lit9 398 88 8 1 0 FF
unlit9 382 88 8 0 0 00
hit0 20 60 0 1 1 E0
hit3 150 78 3 1 1 E0
other3 150 78 4 1 0 FF
hit7 318 96 7 1 1 E0
other8 342 70 7 1 0 FF
unlitMatch5 238 70 5 0 0 00
hit9 398 88 9 1 1 E0
hit9Corner 403 60 9 1 1 E0
rightEdge0 44 60 1 0 0 00
lastColumn0 43 60 1 1 0 FF
bottomEdge0 20 100 1 0 0 00
lastRow0 20 99 1 1 0 FF
gap01 50 70 6 0 0 00
rightEdge9 404 60 6 0 0 00
leftOfRow 19 60 6 0 0 00
aboveRow 20 59 6 0 0 00

//--- verification/scoreDisplayTb.sv
`timescale 1ns/1ps

module scoreDisplayTb;

	localparam int NUMBERS = 10;
	localparam int NUMBERS_SPACE = 40;
	localparam int ROW_LEFT_X = 20;
	localparam int ROW_TOP_Y = 60;
	localparam int HALF_PERIOD_NS = 20; // 40 ns clock
	localparam int RESET_CYCLES = 5;
	localparam int RANDOM_PIXELS = 200;
	localparam int MAX_LINES = 500;
	localparam int DRAIN_LIMIT = 8;

	logic clk;
	logic arstN;
	scorePkg::pixelCoord_t pixelX;
	scorePkg::pixelCoord_t pixelY;
	scorePkg::digit_t scoreNumber;
	logic drawPixel;
	logic drawScore;
	scorePkg::rgb_t rgb;

	scorePkg::digit_t pendingScore;
	int cycle;
	int unsigned lcgState;
	string nameQ [$];
	int dueQ [$];
	logic [9:0] expectQ [$]; // drawPixel, drawScore, rgb

	scoreDisplayTop #(
		.NUMBERS(NUMBERS),
		.NUMBERS_SPACE(NUMBERS_SPACE),
		.ROW_LEFT_X(ROW_LEFT_X),
		.ROW_TOP_Y(ROW_TOP_Y)
	) dut_i (
		.clk(clk),
		.arstN(arstN),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.scoreNumber(scoreNumber),
		.drawPixel(drawPixel),
		.drawScore(drawScore),
		.rgb(rgb)
	);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD_NS clk = ~clk;
	end

	function automatic int unsigned nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState >> 16; // low bits of the generator repeat quickly
	endfunction

	task automatic stopWithFailure();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic compareValue(input string name, input string what, input int expected,
			input int actual);
		assert (actual == expected) else begin
			$display("Mismatch in %s: %s expected 0x%0h actual 0x%0h", name, what, expected,
				actual);
			stopWithFailure();
		end
	endtask

	task automatic checkIdle(input string name);
		compareValue(name, "drawPixel", 0, int'(drawPixel));
		compareValue(name, "drawScore", 0, int'(drawScore));
		compareValue(name, "rgb", int'(scorePkg::BACKGROUND_COLOR), int'(rgb));
	endtask

	task automatic checkDue();
		string name;
		logic [9:0] expected;
		if (dueQ.size() != 0 && dueQ[0] == cycle) begin
			name = nameQ.pop_front();
			expected = expectQ.pop_front();
			void'(dueQ.pop_front());
			compareValue(name, "drawPixel", int'(expected[9]), int'(drawPixel));
			compareValue(name, "drawScore", int'(expected[8]), int'(drawScore));
			compareValue(name, "rgb", int'(expected[7:0]), int'(rgb));
		end
	endtask

	task automatic stepPixel(input string name, input int x, input int y, input int score,
			input int expPixel, input int expScore, input int expRgb);
		@(negedge clk);
		cycle++;
		checkDue();
		pixelX = scorePkg::pixelCoord_t'(x);
		pixelY = scorePkg::pixelCoord_t'(y);
		scoreNumber = pendingScore; // the cell meets the score one cycle after its pixel
		pendingScore = scorePkg::digit_t'(score);
		nameQ.push_back(name);
		dueQ.push_back(cycle + 2);
		expectQ.push_back({expPixel[0], expScore[0], expRgb[7:0]});
	endtask

	task automatic idleCycle();
		@(negedge clk);
		cycle++;
		checkDue();
		scoreNumber = pendingScore;
	endtask

	initial begin
		int fd;
		int count;
		int lines;
		int x;
		int y;
		int score;
		int expPixel;
		int expScore;
		int expRgb;
		string line;
		string name;
		arstN = 1'b0;
		pixelX = scorePkg::pixelCoord_t'(ROW_LEFT_X);
		pixelY = scorePkg::pixelCoord_t'(ROW_TOP_Y);
		scoreNumber = 4'd9;
		pendingScore = 4'd9;
		cycle = 0;
		lcgState = 29;

		// the held pixel is a lit corner of digit 0 so a leak through reset shows up
		for (int i = 1; i < RESET_CYCLES; i++) begin
			stepPixel("reset", ROW_LEFT_X, ROW_TOP_Y, 9, 0, 0, 0);
			checkIdle("reset");
		end
		stepPixel("release", ROW_LEFT_X, ROW_TOP_Y, 9, 1, 0, int'(scorePkg::DIGIT_COLOR));
		checkIdle("reset");
		arstN = 1'b1;

		fd = $fopen("verification/scoreDisplayCases.txt", "r");
		if (fd == 0) begin
			$display("The cases file could not be opened");
			stopWithFailure();
		end else begin
			for (lines = 0; !$feof(fd) && lines < MAX_LINES; lines++) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line[0] != "#") begin
					count = $sscanf(line, "%s %d %d %d %d %d %h", name, x, y, score,
						expPixel, expScore, expRgb);
					if (count != 7) begin
						$display("A line of the cases file could not be parsed: %s", line);
						stopWithFailure();
					end else begin
						stepPixel(name, x, y, score, expPixel, expScore, expRgb);
					end
				end
			end
			$fclose(fd);
		end

		// nothing outside the digit row may ever light up
		for (int i = 0; i < RANDOM_PIXELS; i++) begin
			if (i % 2 == 0) begin
				x = int'(nextRandom() % 2048) - 1024;
				y = int'(nextRandom() % 2048) - 1024;
				if (y >= ROW_TOP_Y && y < ROW_TOP_Y + scorePkg::NUMBER_HEIGHT) begin
					y = y + scorePkg::NUMBER_HEIGHT;
				end
			end else begin
				x = -1 - int'(nextRandom() % 1024);
				y = ROW_TOP_Y + int'(nextRandom() % 40);
			end
			score = int'(nextRandom() % 10);
			stepPixel("random", x, y, score, 0, 0, int'(scorePkg::BACKGROUND_COLOR));
		end

		for (int n = 0; dueQ.size() != 0; n++) begin
			if (n == DRAIN_LIMIT) begin
				$display("Timed out waiting for the last expected outputs");
				stopWithFailure();
			end else begin
				idleCycle();
			end
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- vlog.f
src/scorePkg.sv
src/square.sv
src/numberBitmap.sv
src/obstacle.sv
src/objectsMux.sv
src/scoreDisplayTop.sv
verification/scoreDisplayTb.sv
